// File: rtl/life_pkg.sv
/* Shared grid constants and types for the Life engine.
   Imported by every module that handles rows, addresses or counters. */
package life_pkg;

	//////////////////////////////////////////////////
	// Grid geometry
	//////////////////////////////////////////////////

	localparam int GRID_SIZE = 256; // Cells per row and rows per grid
	localparam int ADDR_BITS = 8;   // Row address width

	// One grid row, bit set means alive
	typedef logic [GRID_SIZE-1:0] cell_row_t;

	// Row address, wraps mod GRID_SIZE so the grid is a vertical torus
	typedef logic [ADDR_BITS-1:0] row_addr_t;

	// Counter widths
	typedef logic [47:0] gen_count_t; // Generations since reset
	typedef logic [23:0] gen_rate_t;  // Generations in the last window

	// Fire button debounce FSM
	typedef enum logic [2:0] {
		idle,
		wait_press,
		wait_pulse,
		wait_long,
		long,
		wait_off,
		wait_long_off
	} debounce_state_t;

endpackage

// File: rtl/button_debounce.sv
/* Fire button debounce: synchronizes the raw level, then gives a one-shot
   pulse on a short press and a level while the button is held long. */
`timescale 1ns/1ps
module button_debounce import life_pkg::*; #(
	parameter int PRESS_CYCLES   = 240000,   // Stable press before the pulse
	parameter int PULSE_CYCLES   = 1200000,  // Lockout after the pulse
	parameter int LONG_CYCLES    = 33554432, // Hold time for auto fire
	parameter int RELEASE_CYCLES = 4800000   // Stable release before idle
) (
	input  logic clk,
	input  logic reset,
	input  logic fire_button,
	output logic short_fire,
	output logic long_fire
);

	logic [2:0] meta;     // Three stage synchronizer
	logic in_s;           // Synchronized button level
	logic [31:0] count1;  // Time since press began
	logic [31:0] count0;  // Time since release
	debounce_state_t state;
	debounce_state_t state_next;

	always_ff @(posedge clk) begin
		meta <= {meta[1:0], fire_button};
	end
	assign in_s = meta[2];

	//////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			idle:          state_next = in_s ? wait_press : idle;
			wait_press: begin
				if (!in_s)
					state_next = idle; // Bounce, back out
				else if (count1 == 32'(PRESS_CYCLES))
					state_next = wait_pulse;
			end
			wait_pulse: begin
				if (count1 == 32'(PULSE_CYCLES))
					state_next = wait_long; // Ignores the button meanwhile
			end
			wait_long: begin
				if (!in_s)
					state_next = wait_off;
				else if (count1 >= 32'(LONG_CYCLES))
					state_next = long;
			end
			long:          state_next = in_s ? long : wait_long_off;
			wait_off: begin
				if (in_s)
					state_next = wait_long; // Pressed again, keep timing
				else if (count0 == 32'(RELEASE_CYCLES))
					state_next = idle;
			end
			wait_long_off: begin
				if (in_s)
					state_next = long;
				else if (count0 == 32'(RELEASE_CYCLES))
					state_next = idle;
			end
			default:       state_next = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= idle;
			short_fire <= 1'b0;
		end else begin
			state      <= state_next;
			short_fire <= (state_next == wait_pulse) && (state != wait_pulse); // Entry pulse
		end
	end

	// Auto fire level, kept through the release filter
	assign long_fire = (state == long) || (state == wait_long_off);

	//////////////////////////////////////////////////
	// Timers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			count0 <= '0;
			count1 <= '0;
		end else begin
			count1 <= (state == idle) ? '0 : count1 + 32'd1;
			if (state == wait_off || state == wait_long_off)
				count0 <= count0 + 32'd1; // Only counts while released
			else
				count0 <= '0;
		end
	end

endmodule

// File: rtl/generation_sequencer.sv
/* Pass sequencer: sweeps the row counter over one pass, issues read and write
   rows relative to base, rotates base and restarts or idles at the end. */
`timescale 1ns/1ps
module generation_sequencer import life_pkg::*; #(
	parameter int GENS = 10 // Generations per pass
) (
	input  logic clk,
	input  logic reset,
	input  logic short_fire,
	input  logic long_fire,
	input  logic read_pend,
	output row_addr_t seq_raddr,
	output row_addr_t seq_waddr,
	output row_addr_t base,
	output logic seq_we,
	output logic seq_active,
	output logic shift_en,
	output logic gen_tick
);

	//////////////////////////////////////////////////
	// Pass geometry
	//////////////////////////////////////////////////

	// Read issue to write data, through arbiter, RAM and pipeline
	localparam int PIPE_DEPTH  = 4 + 3 * GENS;
	// Rows -GENS to 255+GENS are read, then the pipeline drains
	localparam int PASS_CYCLES = GRID_SIZE + 2 * GENS + PIPE_DEPTH;
	localparam int CW          = $clog2(PASS_CYCLES + 1);
	localparam int WRITE_FIRST = 2 * GENS + PIPE_DEPTH; // Count when new row 0 appears

	localparam logic [CW-1:0] IDLE_COUNT  = '1; // Above every pass value
	localparam logic [CW-1:0] START_COUNT = '0;
	localparam logic [CW-1:0] DONE_COUNT  = CW'(PASS_CYCLES - 1);

	logic [CW-1:0] row_cnt;
	logic [CW-1:0] rd_row;  // Read row, offset back by GENS
	logic [CW-1:0] wr_row;  // Write row, offset by pipeline and GENS
	logic pass_done;
	logic go;

	assign go        = short_fire || long_fire;
	assign pass_done = (row_cnt == DONE_COUNT);

	always_ff @(posedge clk) begin
		if (reset) begin
			row_cnt <= IDLE_COUNT;
			base    <= '0;
		end else begin
			if (row_cnt == IDLE_COUNT) begin
				row_cnt <= go ? START_COUNT : IDLE_COUNT;
			end else if (pass_done) begin
				// Held button restarts, unless a readout is waiting
				row_cnt <= (long_fire && !read_pend) ? START_COUNT : IDLE_COUNT;
				base    <= base + ADDR_BITS'(GENS); // New grid starts GENS rows on
			end else begin
				row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Addresses and strobes
	//////////////////////////////////////////////////

	assign rd_row = row_cnt - CW'(GENS);
	// New row j lands at (base + GENS) + j, written when count = j + WRITE_FIRST
	assign wr_row = row_cnt - CW'(GENS + PIPE_DEPTH);

	assign seq_raddr  = rd_row[ADDR_BITS-1:0];    // Wraps mod GRID_SIZE
	assign seq_waddr  = wr_row[ADDR_BITS-1:0];
	assign seq_active = (row_cnt != IDLE_COUNT);
	assign seq_we     = (row_cnt >= CW'(WRITE_FIRST)) && (row_cnt <= DONE_COUNT);
	assign shift_en   = seq_active; // Pipeline steps on every pass cycle
	assign gen_tick   = pass_done;

endmodule

// File: rtl/life_pipeline.sv
/* Generation pipeline: GENS chained stages, each a three-row window that
   applies the Life rule with wrap at the row ends. */
`timescale 1ns/1ps
module life_pipeline import life_pkg::*; #(
	parameter int GENS = 10 // Number of chained stages
) (
	input  logic clk,
	input  logic shift_en,
	input  cell_row_t ram_rdata,
	output cell_row_t next_row
);

	cell_row_t rdata_q;            // RAM row, registered once
	cell_row_t stage_out [GENS];   // New row from each stage

	always_ff @(posedge clk) begin
		if (shift_en)
			rdata_q <= ram_rdata;
	end

	//////////////////////////////////////////////////
	// Stages, three cycles each
	//////////////////////////////////////////////////

	for (genvar g = 0; g < GENS; g++) begin : stage
		cell_row_t in_row;
		cell_row_t in_q;
		cell_row_t w0, w1, w2;           // Newest to oldest row
		logic [1:0] add3_q [GRID_SIZE];  // Column sums, window one step back

		if (g == 0) begin : first
			assign in_row = rdata_q;
		end else begin : chain
			assign in_row = stage_out[g-1];
		end

		always_ff @(posedge clk) begin
			if (shift_en) begin
				in_q <= in_row;
				w2   <= w1;
				w1   <= w0;
				w0   <= in_q;
				for (int i = 0; i < GRID_SIZE; i++)
					add3_q[i] <= 2'(w0[i]) + 2'(w1[i]) + 2'(w2[i]);
			end
		end

		// Sums are for the window centred on w2
		always_comb begin
			logic [3:0] sum9;
			int lft;
			int rgt;
			for (int i = 0; i < GRID_SIZE; i++) begin
				lft  = (i == 0) ? GRID_SIZE - 1 : i - 1;        // Wrap left edge
				rgt  = (i == GRID_SIZE - 1) ? 0 : i + 1;        // Wrap right edge
				sum9 = 4'(add3_q[lft]) + 4'(add3_q[i]) + 4'(add3_q[rgt]);
				// Sum includes the cell itself
				stage_out[g][i] = (sum9 == 4'd3) || ((sum9 == 4'd4) && w2[i]);
			end
		end
	end

	// Final generation out to the write port
	always_ff @(posedge clk) begin
		if (shift_en)
			next_row <= stage_out[GENS-1];
	end

endmodule

// File: rtl/cell_ram.sv
/* Cell memory: one row per word, one write port and one read port
   with a registered read. */
`timescale 1ns/1ps
module cell_ram import life_pkg::*; (
	input  logic clk,
	input  logic ram_we,
	input  row_addr_t ram_raddr,
	input  row_addr_t ram_waddr,
	input  cell_row_t ram_wdata,
	output cell_row_t ram_rdata
);

	cell_row_t mem [GRID_SIZE]; // Whole grid

	always_ff @(posedge clk) begin
		if (ram_we)
			mem[ram_waddr] <= ram_wdata;
	end

	// Same address read returns the old row
	always_ff @(posedge clk) begin
		ram_rdata <= mem[ram_raddr];
	end

endmodule

// File: rtl/ram_arbiter.sv
/* RAM port steering between sequencer, row loader and row readout.
   External rows are logical and get base added here. */
`timescale 1ns/1ps
module ram_arbiter import life_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic seq_active,
	input  logic seq_we,
	input  logic load_we,
	input  logic read_req,
	input  row_addr_t seq_raddr,
	input  row_addr_t seq_waddr,
	input  row_addr_t base,
	input  row_addr_t load_addr,
	input  row_addr_t read_addr,
	input  cell_row_t next_row,
	input  cell_row_t load_data,
	input  cell_row_t ram_rdata,
	output row_addr_t ram_raddr,
	output row_addr_t ram_waddr,
	output logic ram_we,
	output logic read_pend,
	output logic row_valid,
	output cell_row_t ram_wdata,
	output cell_row_t row_data
);

	row_addr_t pend_addr;
	logic serve;         // Pending read goes out this cycle
	logic [1:0] rd_del;  // Address issued, data at RAM output

	assign serve = read_pend && !seq_active;

	always_ff @(posedge clk) begin
		if (reset) begin
			read_pend <= 1'b0;
			rd_del    <= '0;
			row_valid <= 1'b0;
		end else begin
			if (read_req)
				read_pend <= 1'b1; // Newest request wins
			else if (serve)
				read_pend <= 1'b0;
			rd_del    <= {rd_del[0], serve};
			row_valid <= rd_del[1];
		end
	end

	always_ff @(posedge clk) begin
		if (read_req)
			pend_addr <= read_addr;
		ram_raddr <= base + (seq_active ? seq_raddr : pend_addr); // Registered read address
		if (rd_del[1])
			row_data <= ram_rdata;
	end

	// Write port, loader only between passes
	assign ram_we    = seq_active ? seq_we : load_we;
	assign ram_waddr = base + (seq_active ? seq_waddr : load_addr);
	assign ram_wdata = seq_active ? next_row : load_data;

endmodule

// File: rtl/generation_counters.sv
/* Generation statistics: running total since reset and the count
   latched over each rate window. */
`timescale 1ns/1ps
module generation_counters import life_pkg::*; #(
	parameter int GENS          = 10,       // Generations per tick
	parameter int SECOND_CYCLES = 48000000  // Rate window length
) (
	input  logic clk,
	input  logic reset,
	input  logic gen_tick,
	output gen_count_t total_gens,
	output gen_rate_t gens_per_sec
);

	localparam int SW = $clog2(SECOND_CYCLES + 1);

	logic [SW-1:0] sec_cnt;
	gen_rate_t win_gens;   // Generations so far in this window
	gen_rate_t tick_add;

	assign tick_add = gen_tick ? 24'(GENS) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			total_gens   <= '0;
			sec_cnt      <= '0;
			win_gens     <= '0;
			gens_per_sec <= '0;
		end else begin
			if (gen_tick)
				total_gens <= total_gens + 48'(GENS);
			if (sec_cnt == SW'(SECOND_CYCLES - 1)) begin
				sec_cnt      <= '0;
				gens_per_sec <= win_gens + tick_add; // Tick on the boundary counts here
				win_gens     <= '0;
			end else begin
				sec_cnt  <= sec_cnt + 1'b1;
				win_gens <= win_gens + tick_add;
			end
		end
	end

endmodule

// File: rtl/life_top.sv
/* Life engine top level: debounce, sequencer, pipeline, RAM, arbiter
   and counters wired together on one clock. */
`timescale 1ns/1ps
module life_top import life_pkg::*; #(
	parameter int GENS           = 10,
	parameter int PRESS_CYCLES   = 240000,
	parameter int PULSE_CYCLES   = 1200000,
	parameter int LONG_CYCLES    = 33554432,
	parameter int RELEASE_CYCLES = 4800000,
	parameter int SECOND_CYCLES  = 48000000
) (
	input  logic clk,
	input  logic reset,
	input  logic fire_button,
	input  logic load_we,
	input  row_addr_t load_addr,
	input  cell_row_t load_data,
	input  logic read_req,
	input  row_addr_t read_addr,
	output logic busy,
	output logic row_valid,
	output cell_row_t row_data,
	output gen_count_t total_gens,
	output gen_rate_t gens_per_sec
);

	logic short_fire, long_fire;
	logic seq_we, seq_active, shift_en, gen_tick, read_pend;
	row_addr_t seq_raddr, seq_waddr, base;
	row_addr_t ram_raddr, ram_waddr;
	logic ram_we;
	cell_row_t ram_wdata, ram_rdata, next_row;

	button_debounce #(
		.PRESS_CYCLES(PRESS_CYCLES), .PULSE_CYCLES(PULSE_CYCLES),
		.LONG_CYCLES(LONG_CYCLES), .RELEASE_CYCLES(RELEASE_CYCLES)
	) button_debounce_i (
		.clk, .reset, .fire_button, .short_fire, .long_fire
	);

	generation_sequencer #(.GENS(GENS)) generation_sequencer_i (
		.clk, .reset, .short_fire, .long_fire, .read_pend,
		.seq_raddr, .seq_waddr, .base, .seq_we, .seq_active, .shift_en, .gen_tick
	);

	life_pipeline #(.GENS(GENS)) life_pipeline_i (
		.clk, .shift_en, .ram_rdata, .next_row
	);

	cell_ram cell_ram_i (
		.clk, .ram_we, .ram_raddr, .ram_waddr, .ram_wdata, .ram_rdata
	);

	ram_arbiter ram_arbiter_i (
		.clk, .reset, .seq_active, .seq_we, .load_we, .read_req,
		.seq_raddr, .seq_waddr, .base, .load_addr, .read_addr,
		.next_row, .load_data, .ram_rdata,
		.ram_raddr, .ram_waddr, .ram_we, .read_pend, .row_valid,
		.ram_wdata, .row_data
	);

	generation_counters #(.GENS(GENS), .SECOND_CYCLES(SECOND_CYCLES)) generation_counters_i (
		.clk, .reset, .gen_tick, .total_gens, .gens_per_sec
	);

	assign busy = seq_active; // High for the whole pass

endmodule

// File: verification/life_tests.svh
/* Directed tests for the Life engine, included in the testbench module.
   Each task drives the DUT through one behavior and checks the result. */
`ifndef LIFE_TESTS_SVH
`define LIFE_TESTS_SVH

task automatic test_reset_state();
	$display("Test 1: state after reset");
	compare_value("busy", 0, busy);
	compare_value("row_valid", 0, row_valid);
	compare_value("total_gens", 0, total_gens);
	compare_value("gens_per_sec", 0, gens_per_sec);
endtask

task automatic test_load_readback();
	$display("Test 2: load and read back");
	for (int r = 0; r < GRID_SIZE; r++)
		model[r] = random_row();
	load_grid();
	check_grid();
endtask

task automatic test_short_press();
	// Glider, blinker, row end blinker, top/bottom blinker, corner glider
	int rows [19] = '{10, 11, 12, 12, 12, 100, 100, 100, 60, 60, 60,
		255, 0, 1, 254, 255, 0, 0, 0};
	int cols [19] = '{21, 22, 20, 21, 22, 50, 51, 52, 255, 0, 1,
		128, 128, 128, 255, 0, 254, 255, 0};
	$display("Test 3: short press");
	for (int r = 0; r < GRID_SIZE; r++)
		model[r] = '0;
	for (int i = 0; i < 19; i++)
		model[rows[i]][cols[i]] = 1'b1;
	load_grid();
	hold_button(PRESS_CYCLES + 10); // Gone well before LONG_CYCLES
	wait_busy(1'b1, 20);
	wait_busy(1'b0, PASS_CYCLES + 10);
	exp_total += GENS;
	compare_value("total_gens", exp_total, total_gens);
	advance_model(exp_total);
	check_grid();
endtask

task automatic test_long_hold();
	longint delta;
	$display("Test 4: long hold");
	for (int r = 0; r < GRID_SIZE; r++)
		model[r] = random_row() & random_row(); // About a quarter alive
	load_grid();
	hold_button(LONG_CYCLES + 3 * PASS_CYCLES);
	wait_busy(1'b0, 2 * PASS_CYCLES + RELEASE_CYCLES);
	delta = total_gens - exp_total;
	confirm(delta % GENS == 0, "total_gens did not grow by whole passes");
	confirm(delta >= 2 * GENS, "held button ran fewer than two passes");
	exp_total = total_gens;
	advance_model(exp_total);
	check_grid();
endtask

task automatic test_read_during_pass();
	cell_row_t data;
	bit idle_seen;
	int addr;
	int waited = 0;
	$display("Test 5: read during a pass");
	addr = $random(seed) & (GRID_SIZE - 1);
	fire_button = 1'b1;
	wait_busy(1'b1, PRESS_CYCLES + 10);
	while (total_gens == exp_total && waited < PASS_CYCLES + 10) begin
		next_cycle(); // Auto fire takes over during the first pass
		waited++;
	end
	confirm(total_gens != exp_total, "first pass of the hold did not finish");
	repeat (20) next_cycle();
	confirm(busy, "second pass did not start while held");
	read_row(addr, data, idle_seen);
	confirm(idle_seen, "row_valid came before the pass ended");
	exp_total += 2 * GENS; // Read waits out the second pass
	compare_value("total_gens", exp_total, total_gens);
	advance_model(exp_total);
	compare_row(addr, model[addr], data);
	confirm(busy, "held button did not restart after the read");
	fire_button = 1'b0;
	wait_busy(1'b0, 2 * PASS_CYCLES + RELEASE_CYCLES);
	confirm((total_gens - exp_total) % GENS == 0, "total_gens did not grow by whole passes");
	exp_total = total_gens;
	advance_model(exp_total);
	check_grid();
endtask

task automatic test_rate_window();
	int max_rate;
	$display("Test 6: rate window");
	max_rate = (SECOND_CYCLES + PASS_CYCLES - 1) / PASS_CYCLES * GENS; // Ticks per window
	fire_button = 1'b1;
	repeat (LONG_CYCLES + 3 * SECOND_CYCLES) next_cycle();
	confirm(gens_per_sec != 0, "gens_per_sec stayed zero under auto fire");
	confirm(gens_per_sec % GENS == 0, "gens_per_sec is not a whole number of passes");
	confirm(gens_per_sec <= max_rate,
		$sformatf("gens_per_sec %0d is above the limit %0d", gens_per_sec, max_rate));
	fire_button = 1'b0;
	wait_busy(1'b0, 2 * PASS_CYCLES + RELEASE_CYCLES);
	exp_total = total_gens;
endtask

`endif

// File: verification/tb_life_top.sv
/* Testbench for the Life engine. Holds the torus reference model, shared
   driver tasks and the watchdog, and runs the directed tests in order. */
`timescale 1ns/1ps
module tb_life_top import life_pkg::*; ();

	localparam int GENS           = 2;
	localparam int PRESS_CYCLES   = 5;
	localparam int PULSE_CYCLES   = 20;
	localparam int LONG_CYCLES    = 200;
	localparam int RELEASE_CYCLES = 50;
	localparam int SECOND_CYCLES  = 5000;
	localparam int CLK_PERIOD     = 100;
	localparam int PASS_CYCLES    = GRID_SIZE + 2 * GENS + 4 + 3 * GENS; // Sweep plus drain
	localparam int READ_WAIT      = PASS_CYCLES + 16;  // Worst case read deferral
	localparam int NUM_TESTS      = 6;
	localparam int LONGEST_TEST   = LONG_CYCLES + 4 * SECOND_CYCLES; // Rate window test

	logic clk, reset, fire_button, load_we, read_req, busy, row_valid;
	row_addr_t load_addr, read_addr;
	cell_row_t load_data, row_data;
	gen_count_t total_gens;
	gen_rate_t gens_per_sec;

	cell_row_t model [GRID_SIZE]; // Expected grid, logical rows
	longint model_total;          // Generation count the model stands at
	longint exp_total;            // Expected total_gens
	integer seed = 32'h464fee12;
	int value_errors = 0;
	int other_errors = 0;

	life_top #(
		.GENS(GENS), .PRESS_CYCLES(PRESS_CYCLES), .PULSE_CYCLES(PULSE_CYCLES),
		.LONG_CYCLES(LONG_CYCLES), .RELEASE_CYCLES(RELEASE_CYCLES),
		.SECOND_CYCLES(SECOND_CYCLES)
	) life_top_i (
		.clk, .reset, .fire_button, .load_we, .load_addr, .load_data, .read_req,
		.read_addr, .busy, .row_valid, .row_data, .total_gens, .gens_per_sec
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Checks and driver helpers
	//////////////////////////////////////////////////

	task automatic compare_row(input int addr, input cell_row_t exp, input cell_row_t act);
		assert (act === exp) else begin
			$display("[FAIL] row_data row %02h: expected %064h, actual %064h", addr, exp, act);
			value_errors++;
		end
	endtask

	task automatic compare_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		assert (act === exp) else begin
			$display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic confirm(input bit cond, input string msg);
		assert (cond) else begin
			$display("Error: %s", msg);
			other_errors++;
		end
	endtask

	task automatic next_cycle(); // Drive and sample point
		@(posedge clk);
		#1;
	endtask

	function automatic cell_row_t random_row();
		cell_row_t r;
		for (int i = 0; i < GRID_SIZE / 32; i++)
			r[i*32 +: 32] = $random(seed);
		return r;
	endfunction

	task automatic hold_button(input int cycles);
		fire_button = 1'b1;
		repeat (cycles) next_cycle();
		fire_button = 1'b0;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int waited = 0;
		while (busy !== level && waited < limit) begin
			next_cycle();
			waited++;
		end
		confirm(busy === level, $sformatf("busy did not go to %0b in %0d cycles", level, limit));
	endtask

	task automatic load_grid(); // Whole model into the DUT, idle only
		for (int r = 0; r < GRID_SIZE; r++) begin
			load_we   = 1'b1;
			load_addr = row_addr_t'(r);
			load_data = model[r];
			next_cycle();
		end
		load_we = 1'b0;
		model_total = exp_total;
	endtask

	// One readout, notes whether busy was seen low on the way
	task automatic read_row(input int addr, output cell_row_t data, output bit idle_seen);
		int waited = 0;
		bit got = 1'b0;
		read_req  = 1'b1;
		read_addr = row_addr_t'(addr);
		next_cycle();
		read_req  = 1'b0;
		idle_seen = 1'b0;
		while (!got && waited < READ_WAIT) begin
			idle_seen |= !busy;
			next_cycle();
			waited++;
			got = row_valid;
		end
		data = row_data;
		confirm(got, $sformatf("no row_valid after reading row %0d", addr));
	endtask

	task automatic check_grid();
		cell_row_t data;
		bit idle_seen;
		for (int r = 0; r < GRID_SIZE; r++) begin
			read_row(r, data, idle_seen);
			compare_row(r, model[r], data);
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model, B3/S23 on the torus
	//////////////////////////////////////////////////

	task automatic step_model();
		cell_row_t nxt [GRID_SIZE];
		int n, rr, cc;
		for (int r = 0; r < GRID_SIZE; r++) begin
			for (int c = 0; c < GRID_SIZE; c++) begin
				n = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						rr = (r + dr + GRID_SIZE) % GRID_SIZE; // Vertical wrap
						cc = (c + dc + GRID_SIZE) % GRID_SIZE; // Horizontal wrap
						if (dr != 0 || dc != 0)
							n += int'(model[rr][cc]);
					end
				end
				nxt[r][c] = (n == 3) || (n == 2 && model[r][c]);
			end
		end
		model = nxt;
		model_total++;
	endtask

	task automatic advance_model(input longint target);
		while (model_total < target)
			step_model();
	endtask

	`include "life_tests.svh"

	initial begin
		#(longint'(NUM_TESTS) * LONGEST_TEST * CLK_PERIOD);
		$display("Watchdog: run went past %0d cycles", NUM_TESTS * LONGEST_TEST);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		reset       = 1'b1;
		fire_button = 1'b0;
		load_we     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		read_req    = 1'b0;
		read_addr   = '0;
		model_total = 0;
		exp_total   = 0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset_state();
		test_load_readback();
		test_short_press();
		test_long_hold();
		test_read_during_pass();
		test_rate_window();
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: project.f
+incdir+verification
rtl/life_pkg.sv
rtl/button_debounce.sv
rtl/generation_sequencer.sv
rtl/life_pipeline.sv
rtl/cell_ram.sv
rtl/ram_arbiter.sv
rtl/generation_counters.sv
rtl/life_top.sv
verification/tb_life_top.sv

// File: run.sh
#!/bin/sh
# Builds the Life engine testbench with Verilator and runs it.
# The script fails unless the pass line shows up in the simulation output.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_life_top -f project.f &&
./obj_dir/Vtb_life_top | tee /dev/stderr | grep -qx "PASS: all tests" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
